/* verilog/rename_pkg.sv */
// register numbering for the rename stage
package rename_pkg;

    // architectural side, x0 reads as zero
    localparam int NUM_ARCH = 32;
    localparam int ARCH_W   = $clog2(NUM_ARCH);  // 5 bits

    // physical side, top level may shrink the pool
    localparam int NUM_PRF_DEFAULT = 64;
    localparam int PRF_W           = 6;  // covers any pool up to 64 entries

    // architectural register index
    typedef logic [ARCH_W-1:0] arch_reg_t;

    // physical register tag
    typedef logic [PRF_W-1:0] prf_num_t;

    // x0 has no physical writer; it maps to p0 for good
    localparam arch_reg_t ARCH_ZERO = '0;

endpackage

/* verilog/commit_pkg.sv */
// retirement side of the rename stage
package commit_pkg;

    // instructions retired per cycle
    // the two-slot port lists of free_list and rename_map assume this count
    localparam int COMMIT_SLOTS = 2;

    // one bit per retire slot, slot 0 oldest
    typedef logic [COMMIT_SLOTS-1:0] commit_mask_t;

endpackage

/* verilog/freelist_enc.sv */
`timescale 1ns/1ps

// lowest free entry of a physical register bitmap
// 1 = in use, 0 = free
module freelist_enc #(
    parameter int NUM_PRF = 64
) (
    input  logic [NUM_PRF-1:0]    free_list,
    output logic                  free_valid,
    output rename_pkg::prf_num_t  free_num
);

    // scan from the top down so the last hit is the lowest index
    always_comb begin
        free_valid = 1'b0;
        free_num   = '0;
        for (int i = NUM_PRF - 1; i >= 0; i--) begin
            if (!free_list[i]) begin
                free_valid = 1'b1;
                free_num   = rename_pkg::prf_num_t'(i);
            end
        end
    end

endmodule

/* verilog/free_list.sv */
`timescale 1ns/1ps

// speculative and committed free bitmaps
// two-wide allocation, commit release, one-cycle recovery
module free_list #(
    parameter int NUM_PRF = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  recover,
    // rename side
    input  logic                  inst_0_req,
    input  logic                  inst_1_req,
    output rename_pkg::prf_num_t  inst_0_prf,
    output rename_pkg::prf_num_t  inst_1_prf,
    output logic                  rename_ok,  // all requesting slots served
    // stale tags from the committed map
    input  logic                  stale_valid_0,
    input  logic                  stale_valid_1,
    input  rename_pkg::prf_num_t  stale_prf_0,
    input  rename_pkg::prf_num_t  stale_prf_1,
    // tags handed out at rename, now retiring
    input  logic                  commit_valid_0,
    input  logic                  commit_valid_1,
    input  rename_pkg::prf_num_t  commit_prf_0,
    input  rename_pkg::prf_num_t  commit_prf_1
);

    // p0..p31 back x0..x31 out of reset
    localparam logic [NUM_PRF-1:0] RESET_BM =
        {{(NUM_PRF - rename_pkg::NUM_ARCH){1'b0}}, {rename_pkg::NUM_ARCH{1'b1}}};
    localparam logic [NUM_PRF-1:0] ZERO_BIT = {{(NUM_PRF - 1){1'b0}}, 1'b1};

    logic [NUM_PRF-1:0] spec_bm;     // in-flight view
    logic [NUM_PRF-1:0] comm_bm;     // retired view
    logic [NUM_PRF-1:0] after_0_bm;  // slot 0 pick applied
    logic [NUM_PRF-1:0] after_1_bm;  // both picks applied
    logic [NUM_PRF-1:0] alloc_bm;
    logic [NUM_PRF-1:0] spec_next;
    logic [NUM_PRF-1:0] comm_next;

    logic                 free_valid_0;
    logic                 free_valid_1;
    rename_pkg::prf_num_t free_num_0;
    rename_pkg::prf_num_t free_num_1;

    // commit ports gathered per slot
    commit_pkg::commit_mask_t stale_v;
    commit_pkg::commit_mask_t commit_v;
    rename_pkg::prf_num_t     stale_tag [commit_pkg::COMMIT_SLOTS];
    rename_pkg::prf_num_t     commit_tag[commit_pkg::COMMIT_SLOTS];

    function automatic logic [NUM_PRF-1:0] tag_bit(input rename_pkg::prf_num_t tag);
        tag_bit = ZERO_BIT << tag;
    endfunction

    freelist_enc #(
        .NUM_PRF    (NUM_PRF)
    ) enc_0 (
        .free_list  (spec_bm),
        .free_valid (free_valid_0),
        .free_num   (free_num_0)
    );

    // slot 1 must not pick what slot 0 just took
    assign after_0_bm = inst_0_req ? (spec_bm | tag_bit(free_num_0)) : spec_bm;

    freelist_enc #(
        .NUM_PRF    (NUM_PRF)
    ) enc_1 (
        .free_list  (after_0_bm),
        .free_valid (free_valid_1),
        .free_num   (free_num_1)
    );

    assign after_1_bm = inst_1_req ? (after_0_bm | tag_bit(free_num_1)) : after_0_bm;

    // all or nothing, no request counts as ok
    assign rename_ok = (!inst_0_req || free_valid_0) && (!inst_1_req || free_valid_1);
    assign alloc_bm  = rename_ok ? after_1_bm : spec_bm;  // stall keeps the map untouched

    assign inst_0_prf = free_num_0;
    assign inst_1_prf = free_num_1;

    assign stale_v       = {stale_valid_1, stale_valid_0};
    assign commit_v      = {commit_valid_1, commit_valid_0};
    assign stale_tag[0]  = stale_prf_0;
    assign stale_tag[1]  = stale_prf_1;
    assign commit_tag[0] = commit_prf_0;
    assign commit_tag[1] = commit_prf_1;

    // retire in slot order so slot 1 sees slot 0
    always_comb begin
        spec_next = alloc_bm;
        comm_next = comm_bm;
        for (int s = 0; s < commit_pkg::COMMIT_SLOTS; s++) begin
            if (stale_v[s]) begin
                spec_next = spec_next & ~tag_bit(stale_tag[s]);  // old mapping dead
                comm_next = comm_next & ~tag_bit(stale_tag[s]);
            end
            // x0 writers hold no tag, stale_v already excludes them
            if (commit_v[s] && stale_v[s]) begin
                comm_next = comm_next | tag_bit(commit_tag[s]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_bm <= RESET_BM;
        end else if (recover) begin
            spec_bm <= comm_bm | ZERO_BIT;  // retired set before this edge
        end else begin
            spec_bm <= spec_next | ZERO_BIT;  // p0 never handed out
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comm_bm <= RESET_BM;
        end else begin
            comm_bm <= comm_next | ZERO_BIT;
        end
    end

endmodule

/* verilog/rename_map.sv */
`timescale 1ns/1ps

// speculative and committed map tables
// in-group bypass, stale lookup at commit, recovery copy
module rename_map (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   recover,
    // rename group
    input  logic                   inst_0_valid,
    input  logic                   inst_1_valid,
    input  rename_pkg::arch_reg_t  inst_0_rd,
    input  rename_pkg::arch_reg_t  inst_0_rs1,
    input  rename_pkg::arch_reg_t  inst_0_rs2,
    input  rename_pkg::arch_reg_t  inst_1_rd,
    input  rename_pkg::arch_reg_t  inst_1_rs1,
    input  rename_pkg::arch_reg_t  inst_1_rs2,
    // handshake with the free list
    output logic                   inst_0_req,
    output logic                   inst_1_req,
    input  rename_pkg::prf_num_t   inst_0_prf,
    input  rename_pkg::prf_num_t   inst_1_prf,
    input  logic                   rename_ok,
    // looked-up tags
    output rename_pkg::prf_num_t   inst_0_prs1,
    output rename_pkg::prf_num_t   inst_0_prs2,
    output rename_pkg::prf_num_t   inst_0_old_prd,
    output rename_pkg::prf_num_t   inst_1_prs1,
    output rename_pkg::prf_num_t   inst_1_prs2,
    output rename_pkg::prf_num_t   inst_1_old_prd,
    // retire side
    input  logic                   commit_valid_0,
    input  logic                   commit_valid_1,
    input  rename_pkg::arch_reg_t  commit_rd_0,
    input  rename_pkg::arch_reg_t  commit_rd_1,
    input  rename_pkg::prf_num_t   commit_prf_0,
    input  rename_pkg::prf_num_t   commit_prf_1,
    output logic                   stale_valid_0,
    output logic                   stale_valid_1,
    output rename_pkg::prf_num_t   stale_prf_0,
    output rename_pkg::prf_num_t   stale_prf_1
);

    rename_pkg::prf_num_t spec_map [rename_pkg::NUM_ARCH];  // in-flight mapping
    rename_pkg::prf_num_t comm_map [rename_pkg::NUM_ARCH];  // retired mapping
    rename_pkg::prf_num_t comm_next[rename_pkg::NUM_ARCH];

    // in-group hazards on slot 1
    logic hit_rs1;
    logic hit_rs2;
    logic hit_rd;
    logic stale_hit;  // both retire slots name the same rd

    // retire ports gathered per slot
    commit_pkg::commit_mask_t  retire_v;
    rename_pkg::arch_reg_t     retire_rd [commit_pkg::COMMIT_SLOTS];
    rename_pkg::prf_num_t      retire_prf[commit_pkg::COMMIT_SLOTS];

    // x0 never needs a new tag
    assign inst_0_req = inst_0_valid && (inst_0_rd != rename_pkg::ARCH_ZERO);
    assign inst_1_req = inst_1_valid && (inst_1_rd != rename_pkg::ARCH_ZERO);

    // slot 0 reads the table as is
    assign inst_0_prs1    = spec_map[inst_0_rs1];
    assign inst_0_prs2    = spec_map[inst_0_rs2];
    assign inst_0_old_prd = spec_map[inst_0_rd];

    // slot 1 sees slot 0's new tag first
    assign hit_rs1 = inst_0_req && (inst_1_rs1 == inst_0_rd);
    assign hit_rs2 = inst_0_req && (inst_1_rs2 == inst_0_rd);
    assign hit_rd  = inst_0_req && (inst_1_rd == inst_0_rd);  // waw inside the group

    assign inst_1_prs1    = hit_rs1 ? inst_0_prf : spec_map[inst_1_rs1];
    assign inst_1_prs2    = hit_rs2 ? inst_0_prf : spec_map[inst_1_rs2];
    assign inst_1_old_prd = hit_rd  ? inst_0_prf : spec_map[inst_1_rd];

    // stale tags come from the committed table
    assign stale_valid_0 = commit_valid_0 && (commit_rd_0 != rename_pkg::ARCH_ZERO);
    assign stale_valid_1 = commit_valid_1 && (commit_rd_1 != rename_pkg::ARCH_ZERO);
    assign stale_hit     = stale_valid_0 && (commit_rd_1 == commit_rd_0);

    assign stale_prf_0 = comm_map[commit_rd_0];
    assign stale_prf_1 = stale_hit ? commit_prf_0 : comm_map[commit_rd_1];

    assign retire_v      = {stale_valid_1, stale_valid_0};
    assign retire_rd[0]  = commit_rd_0;
    assign retire_rd[1]  = commit_rd_1;
    assign retire_prf[0] = commit_prf_0;
    assign retire_prf[1] = commit_prf_1;

    // committed table after this cycle's retire, later slot wins
    always_comb begin
        for (int a = 0; a < rename_pkg::NUM_ARCH; a++) begin
            comm_next[a] = comm_map[a];
        end
        for (int s = 0; s < commit_pkg::COMMIT_SLOTS; s++) begin
            if (retire_v[s]) begin
                comm_next[retire_rd[s]] = retire_prf[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < rename_pkg::NUM_ARCH; a++) begin
                spec_map[a] <= rename_pkg::prf_num_t'(a);  // identity map
            end
        end else if (recover) begin
            for (int a = 0; a < rename_pkg::NUM_ARCH; a++) begin
                spec_map[a] <= comm_next[a];  // group in flight is dropped
            end
        end else if (rename_ok) begin
            if (inst_0_req) begin
                spec_map[inst_0_rd] <= inst_0_prf;
            end
            if (inst_1_req) begin
                spec_map[inst_1_rd] <= inst_1_prf;  // overrides slot 0 on same rd
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < rename_pkg::NUM_ARCH; a++) begin
                comm_map[a] <= rename_pkg::prf_num_t'(a);
            end
        end else begin
            for (int a = 0; a < rename_pkg::NUM_ARCH; a++) begin
                comm_map[a] <= comm_next[a];
            end
        end
    end

endmodule

/* verilog/rename_stage.sv */
`timescale 1ns/1ps

// two-wide register rename, free list plus map table
module rename_stage #(
    parameter int NUM_PRF = rename_pkg::NUM_PRF_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   recover,  // restore retired state
    // rename group
    input  logic                   inst_0_valid,
    input  rename_pkg::arch_reg_t  inst_0_rd,
    input  rename_pkg::arch_reg_t  inst_0_rs1,
    input  rename_pkg::arch_reg_t  inst_0_rs2,
    input  logic                   inst_1_valid,
    input  rename_pkg::arch_reg_t  inst_1_rd,
    input  rename_pkg::arch_reg_t  inst_1_rs1,
    input  rename_pkg::arch_reg_t  inst_1_rs2,
    output rename_pkg::prf_num_t   inst_0_prd,
    output rename_pkg::prf_num_t   inst_0_prs1,
    output rename_pkg::prf_num_t   inst_0_prs2,
    output rename_pkg::prf_num_t   inst_0_old_prd,
    output rename_pkg::prf_num_t   inst_1_prd,
    output rename_pkg::prf_num_t   inst_1_prs1,
    output rename_pkg::prf_num_t   inst_1_prs2,
    output rename_pkg::prf_num_t   inst_1_old_prd,
    output logic                   rename_ok,  // low = hold group and retry
    // retire
    input  logic                   commit_valid_0,
    input  rename_pkg::arch_reg_t  commit_rd_0,
    input  rename_pkg::prf_num_t   commit_prf_0,
    input  logic                   commit_valid_1,
    input  rename_pkg::arch_reg_t  commit_rd_1,
    input  rename_pkg::prf_num_t   commit_prf_1
);

    logic                 inst_0_req;
    logic                 inst_1_req;
    logic                 stale_valid_0;
    logic                 stale_valid_1;
    rename_pkg::prf_num_t stale_prf_0;
    rename_pkg::prf_num_t stale_prf_1;

    free_list #(
        .NUM_PRF        (NUM_PRF)
    ) u_free_list (
        .clk            (clk),
        .rst            (rst),
        .recover        (recover),
        .inst_0_req     (inst_0_req),
        .inst_1_req     (inst_1_req),
        .inst_0_prf     (inst_0_prd),  // new destination tags
        .inst_1_prf     (inst_1_prd),
        .rename_ok      (rename_ok),
        .stale_valid_0  (stale_valid_0),
        .stale_valid_1  (stale_valid_1),
        .stale_prf_0    (stale_prf_0),
        .stale_prf_1    (stale_prf_1),
        .commit_valid_0 (commit_valid_0),
        .commit_valid_1 (commit_valid_1),
        .commit_prf_0   (commit_prf_0),
        .commit_prf_1   (commit_prf_1)
    );

    rename_map u_rename_map (
        .clk            (clk),
        .rst            (rst),
        .recover        (recover),
        .inst_0_valid   (inst_0_valid),
        .inst_1_valid   (inst_1_valid),
        .inst_0_rd      (inst_0_rd),
        .inst_0_rs1     (inst_0_rs1),
        .inst_0_rs2     (inst_0_rs2),
        .inst_1_rd      (inst_1_rd),
        .inst_1_rs1     (inst_1_rs1),
        .inst_1_rs2     (inst_1_rs2),
        .inst_0_req     (inst_0_req),
        .inst_1_req     (inst_1_req),
        .inst_0_prf     (inst_0_prd),
        .inst_1_prf     (inst_1_prd),
        .rename_ok      (rename_ok),
        .inst_0_prs1    (inst_0_prs1),
        .inst_0_prs2    (inst_0_prs2),
        .inst_0_old_prd (inst_0_old_prd),
        .inst_1_prs1    (inst_1_prs1),
        .inst_1_prs2    (inst_1_prs2),
        .inst_1_old_prd (inst_1_old_prd),
        .commit_valid_0 (commit_valid_0),
        .commit_valid_1 (commit_valid_1),
        .commit_rd_0    (commit_rd_0),
        .commit_rd_1    (commit_rd_1),
        .commit_prf_0   (commit_prf_0),
        .commit_prf_1   (commit_prf_1),
        .stale_valid_0  (stale_valid_0),  // to free list release
        .stale_valid_1  (stale_valid_1),
        .stale_prf_0    (stale_prf_0),
        .stale_prf_1    (stale_prf_1)
    );

endmodule

/* tests/tb_rename_stage.sv */
`timescale 1ns/1ps

module tb_rename_stage;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;  // after the rising edge
    localparam int SAMPLE_DLY   = 80;  // just before the next edge
    localparam int RESET_CYCLES = 8;
    localparam int R_FIELDS     = 17;  // 8 inputs, ok flag, 8 tags
    localparam int C_FIELDS     = 3 * commit_pkg::COMMIT_SLOTS;  // valid rd prf per slot
    localparam     STIM_FILE    = "tests/rename_stimulus.txt";

    logic                  clk;
    logic                  rst;
    logic                  recover;
    logic                  inst_0_valid;
    rename_pkg::arch_reg_t inst_0_rd;
    rename_pkg::arch_reg_t inst_0_rs1;
    rename_pkg::arch_reg_t inst_0_rs2;
    logic                  inst_1_valid;
    rename_pkg::arch_reg_t inst_1_rd;
    rename_pkg::arch_reg_t inst_1_rs1;
    rename_pkg::arch_reg_t inst_1_rs2;
    rename_pkg::prf_num_t  inst_0_prd;
    rename_pkg::prf_num_t  inst_0_prs1;
    rename_pkg::prf_num_t  inst_0_prs2;
    rename_pkg::prf_num_t  inst_0_old_prd;
    rename_pkg::prf_num_t  inst_1_prd;
    rename_pkg::prf_num_t  inst_1_prs1;
    rename_pkg::prf_num_t  inst_1_prs2;
    rename_pkg::prf_num_t  inst_1_old_prd;
    logic                  rename_ok;
    logic                  commit_valid_0;
    rename_pkg::arch_reg_t commit_rd_0;
    rename_pkg::prf_num_t  commit_prf_0;
    logic                  commit_valid_1;
    rename_pkg::arch_reg_t commit_rd_1;
    rename_pkg::prf_num_t  commit_prf_1;

    int ren_fld [R_FIELDS];  // current rename line
    int com_fld [C_FIELDS];  // current commit line
    int op_no    = 0;
    int op_total = 0;
    bit sized    = 1'b0;  // op_total known

    rename_stage #(
        .NUM_PRF (rename_pkg::NUM_PRF_DEFAULT)
    ) u_rename_stage (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one cycle per operation plus reset and some slack
    initial begin
        wait (sized);
        repeat (op_total + 20) @(posedge clk);
        abort_run($sformatf("timeout: no finish after %0d cycles", op_total + 20));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_prf(input rename_pkg::prf_num_t got, input rename_pkg::prf_num_t exp,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: op %0d %s is %0d, expected %0d",
                                $time, op_no, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: op %0d %s is %b, expected %b",
                                $time, op_no, what, got, exp));
        end
    endtask

    // blank lines and # lines carry no operation
    function automatic bit is_op_line(input string line);
        string op;
        if ($sscanf(line, "%s", op) != 1) begin
            return 1'b0;
        end
        return op[0] != "#";
    endfunction

    function automatic string tag_name(input int i);
        string kind;
        case (i % 4)
            0:       kind = "prd";
            1:       kind = "prs1";
            2:       kind = "prs2";
            default: kind = "old_prd";
        endcase
        return $sformatf("inst_%0d_%s", i / 4, kind);
    endfunction

    // all DUT inputs from the field arrays
    task automatic drive_all(input logic rec);
        recover        = rec;
        inst_0_valid   = ren_fld[0] != 0;
        inst_0_rd      = rename_pkg::arch_reg_t'(ren_fld[1]);
        inst_0_rs1     = rename_pkg::arch_reg_t'(ren_fld[2]);
        inst_0_rs2     = rename_pkg::arch_reg_t'(ren_fld[3]);
        inst_1_valid   = ren_fld[4] != 0;
        inst_1_rd      = rename_pkg::arch_reg_t'(ren_fld[5]);
        inst_1_rs1     = rename_pkg::arch_reg_t'(ren_fld[6]);
        inst_1_rs2     = rename_pkg::arch_reg_t'(ren_fld[7]);
        commit_valid_0 = com_fld[0] != 0;
        commit_rd_0    = rename_pkg::arch_reg_t'(com_fld[1]);
        commit_prf_0   = rename_pkg::prf_num_t'(com_fld[2]);
        commit_valid_1 = com_fld[3] != 0;
        commit_rd_1    = rename_pkg::arch_reg_t'(com_fld[4]);
        commit_prf_1   = rename_pkg::prf_num_t'(com_fld[5]);
    endtask

    task automatic check_group();
        rename_pkg::prf_num_t got [8];
        got[0] = inst_0_prd;
        got[1] = inst_0_prs1;
        got[2] = inst_0_prs2;
        got[3] = inst_0_old_prd;
        got[4] = inst_1_prd;
        got[5] = inst_1_prs1;
        got[6] = inst_1_prs2;
        got[7] = inst_1_old_prd;
        check_flag(rename_ok, ren_fld[8] != 0, "rename_ok");
        for (int i = 0; i < 8; i++) begin
            if (ren_fld[9 + i] >= 0) begin  // -1 = left open by the rules
                check_prf(got[i], rename_pkg::prf_num_t'(ren_fld[9 + i]), tag_name(i));
            end
        end
    endtask

    task automatic run_line(input string line);
        string op;
        int    n;
        logic  rec;
        n   = $sscanf(line, "%s", op);
        rec = 1'b0;
        foreach (ren_fld[i]) begin
            ren_fld[i] = 0;
        end
        foreach (com_fld[i]) begin
            com_fld[i] = 0;
        end
        if (op == "R") begin
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", op,
                        ren_fld[0], ren_fld[1], ren_fld[2], ren_fld[3], ren_fld[4],
                        ren_fld[5], ren_fld[6], ren_fld[7], ren_fld[8], ren_fld[9],
                        ren_fld[10], ren_fld[11], ren_fld[12], ren_fld[13], ren_fld[14],
                        ren_fld[15], ren_fld[16]) - R_FIELDS - 1;
        end else if (op == "C") begin
            n = $sscanf(line, "%s %d %d %d %d %d %d", op, com_fld[0], com_fld[1],
                        com_fld[2], com_fld[3], com_fld[4], com_fld[5]) - C_FIELDS - 1;
        end else if (op == "X" || op == "I") begin
            rec = (op == "X");
            n   = 0;
        end else begin
            n = -1;  // unknown opcode
        end
        if (n != 0) begin
            abort_run($sformatf("stimulus operation %0d is malformed: %s", op_no, line));
        end else begin
            @(posedge clk);
            #(DRIVE_DLY);
            drive_all(rec);
            if (op == "R") begin
                #(SAMPLE_DLY);  // rename outputs are combinational
                check_group();
            end
        end
    endtask

    initial begin
        int    fd;
        int    code;
        string line;
        rst = 1'b1;
        drive_all(1'b0);
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open tests/rename_stimulus.txt, run from the project root");
        end else begin
            while (!$feof(fd)) begin  // first pass sizes the watchdog
                code = $fgets(line, fd);
                if (code > 0 && is_op_line(line)) begin
                    op_total++;
                end
            end
            $fclose(fd);
            sized = 1'b1;
            if (op_total == 0) begin
                abort_run("the stimulus file holds no operations");
            end else begin
                fd = $fopen(STIM_FILE, "r");
                repeat (RESET_CYCLES) @(posedge clk);
                #(DRIVE_DLY);
                rst = 1'b0;
                while (!$feof(fd)) begin
                    code = $fgets(line, fd);
                    if (code > 0 && is_op_line(line)) begin
                        op_no++;
                        run_line(line);
                    end
                end
                $fclose(fd);
                $display("Simulation finished: PASS");
                $finish;
            end
        end
    end

endmodule

/* rename_stage.f */
verilog/rename_pkg.sv
verilog/commit_pkg.sv
verilog/freelist_enc.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/rename_stage.sv
tests/tb_rename_stage.sv

/* Bender.yml */
package:
  name: rename_stage

sources:
  - verilog/rename_pkg.sv
  - verilog/commit_pkg.sv
  - verilog/freelist_enc.sv
  - verilog/free_list.sv
  - verilog/rename_map.sv
  - verilog/rename_stage.sv
  - target: test
    files:
      - tests/tb_rename_stage.sv

/* tests/rename_stimulus.txt */
# R v0 rd0 rs1 rs2 v1 rd1 rs1 rs2 ok prd0 prs1 prs2 old0 prd1 prs1 prs2 old1, -1 = not checked
# C v0 rd0 prf0 v1 rd1 prf1 = commit, X = recover, I = idle; one line per clock cycle
# fresh after reset, lowest free tags first
R 1 5 1 2 1 6 3 4 1 32 1 2 5 33 3 4 6
# slot 1 reads slot 0 rd
R 1 7 5 6 1 8 7 5 1 34 32 33 7 35 34 32 8
# both slots write x9
R 1 9 8 1 1 9 9 7 1 36 35 1 9 37 36 34 36
# x0 destination takes no tag
R 1 0 5 0 1 10 0 9 1 -1 32 0 0 38 0 37 10
# fill the pool up to one free tag
R 1 11 1 2 1 12 3 4 1 39 1 2 11 40 3 4 12
R 1 13 1 2 1 14 3 4 1 41 1 2 13 42 3 4 14
R 1 15 1 2 1 16 3 4 1 43 1 2 15 44 3 4 16
R 1 17 1 2 1 18 3 4 1 45 1 2 17 46 3 4 18
R 1 19 1 2 1 20 3 4 1 47 1 2 19 48 3 4 20
R 1 21 1 2 1 22 3 4 1 49 1 2 21 50 3 4 22
R 1 23 1 2 1 24 3 4 1 51 1 2 23 52 3 4 24
R 1 25 1 2 1 26 3 4 1 53 1 2 25 54 3 4 26
R 1 27 1 2 1 28 3 4 1 55 1 2 27 56 3 4 28
R 1 29 1 2 1 30 3 4 1 57 1 2 29 58 3 4 30
R 1 31 1 2 1 11 3 4 1 59 1 2 31 60 3 4 39
R 1 12 1 2 1 13 3 4 1 61 1 2 40 62 3 4 41
# two requests, one tag left
R 1 14 1 2 1 15 3 4 0 -1 1 2 42 -1 3 4 43
R 1 14 14 1 0 0 0 0 1 63 42 1 42 -1 -1 -1 -1
R 1 15 1 2 0 0 0 0 0 -1 1 2 43 -1 -1 -1 -1
# retire x5 and x6, stale p5 p6 come back
C 1 5 32 1 6 33
R 1 16 5 6 1 17 16 7 1 5 32 33 44 6 5 34 45
# both retire slots write x9
C 1 9 36 1 9 37
I
R 1 18 9 0 1 19 18 18 1 9 37 0 46 36 9 9 47
C 1 7 34 1 0 0
R 1 24 1 2 0 0 0 0 1 7 1 2 52 -1 -1 -1 -1
# back to the retired state
X
R 1 10 5 9 1 11 7 16 1 5 32 37 10 6 34 16 11
R 1 12 10 14 1 13 0 8 1 7 5 14 12 9 0 8 13
R 1 20 1 2 1 21 20 3 1 35 1 2 20 36 35 3 21
R 1 0 24 2 1 0 3 4 1 -1 24 2 0 -1 3 4 0
R 1 22 0 0 1 23 22 21 1 38 0 0 22 39 38 36 23
I
